// File: rtl/icmp_pkg.sv
package icmp_pkg;

	localparam int ICMP_HEADER_BYTES = 8;

	localparam logic [7:0] ICMP_ECHO_REQUEST = 8'd8;
	localparam logic [7:0] ICMP_ECHO_REPLY = 8'd0;

	// type byte 8 -> 0 lowers the sum by 0x0800, so the checksum rises by it
	localparam logic [15:0] ECHO_CHECKSUM_ADJUST = 16'h0800;

	// wire order, first byte in the top bits
	typedef struct packed {
		logic [7:0] icmp_type;
		logic [7:0] code;
		logic [15:0] checksum;
		logic [31:0] rest; // identifier and sequence for echo
	} icmp_header_t;

	typedef struct packed {
		logic [7:0] data;
		logic last;
	} icmp_byte_t;

	typedef struct packed {
		icmp_header_t header;
		logic good;
		logic has_payload;
	} icmp_meta_t;

	// one's complement add with end-around carry
	function automatic logic [15:0] ones_add16(
		input logic [15:0] a,
		input logic [15:0] b
	);
		logic [16:0] s;
		s = {1'b0, a} + {1'b0, b};
		return s[15:0] + {15'd0, s[16]};
	endfunction

endpackage

// File: rtl/fifo_if.sv
`timescale 1ns/1ns

interface fifo_if #(
	parameter type T = logic [7:0]
) ();
	logic push_valid;
	logic push_ready;
	T push_data;

	logic pop_valid;
	logic pop_ready;
	T pop_data;

	modport writer (
		output push_valid,
		output push_data,
		input push_ready
	);

	modport storage (
		input push_valid,
		input push_data,
		output push_ready,
		output pop_valid,
		output pop_data,
		input pop_ready
	);

	modport reader (
		input pop_valid,
		input pop_data,
		output pop_ready
	);
endinterface

// File: rtl/sync_fifo.sv
`timescale 1ns/1ns

module sync_fifo #(
	parameter type T = logic [7:0],
	parameter int DEPTH = 4
) (
	input logic clk,
	input logic reset,
	fifo_if.storage q
);
	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	T mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic do_push;
	logic do_pop;

	function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
		return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
	endfunction

	assign q.push_ready = count < CNT_W'(DEPTH);
	assign q.pop_valid = count != '0;
	assign q.pop_data = mem[rd_ptr]; // head shown directly
	assign do_push = q.push_valid && q.push_ready;
	assign do_pop = q.pop_valid && q.pop_ready;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_push)
				wr_ptr <= next_ptr(wr_ptr);
			if (do_pop)
				rd_ptr <= next_ptr(rd_ptr);
			case ({do_push, do_pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (do_push)
			mem[wr_ptr] <= q.push_data;
	end

endmodule

// File: rtl/icmp_rx.sv
`timescale 1ns/1ns

module icmp_rx (
	input logic clk,
	input logic reset,
	input logic [7:0] in_data,
	input logic in_valid,
	output logic in_ready,
	input logic in_last,
	fifo_if.writer payload_q,
	fifo_if.writer meta_q,
	output logic [15:0] drop_count
);
	import icmp_pkg::*;

	logic live;
	logic [3:0] byte_cnt; // stops at 8, past the header
	logic in_header;
	logic fin_free;
	logic take;
	logic [63:0] hdr_sr;
	logic [7:0] hi_byte;
	logic pair_lo; // next byte is the low half of a word
	logic [15:0] sum;
	logic has_payload;

	// end-of-message stage, overlaps the next message
	logic fin_valid;
	icmp_header_t fin_header;
	logic [15:0] fin_base;
	logic [15:0] fin_word;
	logic fin_long;
	logic fin_payload;
	logic [15:0] folded;
	logic good;

	assign in_header = byte_cnt < 4'(ICMP_HEADER_BYTES);
	assign fin_free = !fin_valid || meta_q.push_ready;

	// a last byte needs the finish stage to be free
	assign in_ready = live && (!in_last || fin_free) && (in_header || payload_q.push_ready);
	assign take = in_valid && in_ready;

	assign payload_q.push_valid = live && in_valid && !in_header && (!in_last || fin_free);
	assign payload_q.push_data = '{data: in_data, last: in_last};

	assign folded = ones_add16(fin_base, fin_word);
	assign good = (folded == 16'hFFFF)
		&& (fin_header.icmp_type == ICMP_ECHO_REQUEST)
		&& (fin_header.code == 8'h00)
		&& fin_long;

	assign meta_q.push_valid = fin_valid;
	assign meta_q.push_data = '{header: fin_header, good: good, has_payload: fin_payload};

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			live <= 1'b0;
			byte_cnt <= '0;
			pair_lo <= 1'b0;
			sum <= '0;
			has_payload <= 1'b0;
			fin_valid <= 1'b0;
			drop_count <= '0;
		end else begin
			live <= 1'b1;
			if (meta_q.push_valid && meta_q.push_ready) begin
				fin_valid <= 1'b0;
				if (!good)
					drop_count <= drop_count + 16'd1;
			end
			if (take) begin
				if (in_last) begin
					byte_cnt <= '0;
					pair_lo <= 1'b0;
					sum <= '0;
					has_payload <= 1'b0;
					fin_valid <= 1'b1; // last word added in the finish stage
				end else begin
					if (in_header)
						byte_cnt <= byte_cnt + 4'd1;
					else
						has_payload <= 1'b1;
					pair_lo <= !pair_lo;
					if (pair_lo)
						sum <= ones_add16(sum, {hi_byte, in_data});
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (take) begin
			if (!pair_lo)
				hi_byte <= in_data;
			if (in_header)
				hdr_sr <= {hdr_sr[55:0], in_data};
			if (in_last) begin
				fin_header <= in_header ? {hdr_sr[55:0], in_data} : hdr_sr;
				fin_base <= sum;
				fin_word <= pair_lo ? {hi_byte, in_data} : {in_data, 8'h00}; // odd tail padded
				fin_long <= byte_cnt >= 4'(ICMP_HEADER_BYTES - 1);
				fin_payload <= has_payload || !in_header;
			end
		end
	end

endmodule

// File: rtl/icmp_tx.sv
`timescale 1ns/1ns

module icmp_tx (
	input logic clk,
	input logic reset,
	fifo_if.reader payload_q,
	fifo_if.reader meta_q,
	output logic [7:0] out_data,
	output logic out_valid,
	input logic out_ready,
	output logic out_last
);
	import icmp_pkg::*;

	typedef enum logic [1:0] {
		IDLE,
		HEADER,
		PAYLOAD,
		DISCARD
	} tx_state_t;

	tx_state_t state;
	logic adv; // output slot frees up this cycle
	icmp_meta_t meta;
	icmp_byte_t pay;
	icmp_header_t reply;
	logic meta_take;
	logic pay_take;
	logic [55:0] hdr_sr;
	logic [2:0] hdr_left;
	logic has_pay;

	assign adv = !out_valid || out_ready;
	assign meta = meta_q.pop_data;
	assign pay = payload_q.pop_data;

	always_comb begin
		reply = meta.header;
		reply.icmp_type = ICMP_ECHO_REPLY;
		reply.checksum = ones_add16(meta.header.checksum, ECHO_CHECKSUM_ADJUST);
	end

	assign meta_q.pop_ready = (state == IDLE) && adv;
	assign payload_q.pop_ready = ((state == PAYLOAD) && adv) || (state == DISCARD);
	assign meta_take = meta_q.pop_valid && meta_q.pop_ready;
	assign pay_take = payload_q.pop_valid && payload_q.pop_ready;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state <= IDLE;
			out_valid <= 1'b0;
			out_last <= 1'b0;
			hdr_left <= '0;
			has_pay <= 1'b0;
		end else begin
			if (adv)
				out_valid <= 1'b0;
			case (state)
				IDLE: begin
					if (meta_take) begin
						has_pay <= meta.has_payload;
						if (meta.good) begin
							out_valid <= 1'b1; // first header byte
							out_last <= 1'b0;
							hdr_left <= 3'(ICMP_HEADER_BYTES - 1);
							state <= HEADER;
						end else if (meta.has_payload) begin
							state <= DISCARD;
						end
					end
				end
				HEADER: begin
					if (adv) begin
						out_valid <= 1'b1;
						out_last <= (hdr_left == 3'd1) && !has_pay;
						hdr_left <= hdr_left - 3'd1;
						if (hdr_left == 3'd1)
							state <= has_pay ? PAYLOAD : IDLE;
					end
				end
				PAYLOAD: begin
					if (pay_take) begin
						out_valid <= 1'b1;
						out_last <= pay.last;
						if (pay.last)
							state <= IDLE;
					end
				end
				DISCARD: begin
					if (pay_take && pay.last)
						state <= IDLE; // dropped payload drained
				end
				default: state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (meta_take) begin
			out_data <= reply.icmp_type;
			hdr_sr <= reply[55:0];
		end else if (state == HEADER && adv) begin
			out_data <= hdr_sr[55:48];
			hdr_sr <= {hdr_sr[47:0], 8'h00};
		end else if (state == PAYLOAD && pay_take) begin
			out_data <= pay.data;
		end
	end

endmodule

// File: rtl/icmp_echo.sv
`timescale 1ns/1ns

module icmp_echo #(
	parameter int PAYLOAD_DEPTH = 64,
	parameter int META_DEPTH = 4
) (
	input logic clk,
	input logic reset,
	input logic [7:0] in_data,
	input logic in_valid,
	output logic in_ready,
	input logic in_last,
	output logic [7:0] out_data,
	output logic out_valid,
	input logic out_ready,
	output logic out_last,
	output logic [15:0] drop_count
);
	import icmp_pkg::*;

	fifo_if #(.T(icmp_byte_t)) payload_q ();
	fifo_if #(.T(icmp_meta_t)) meta_q ();

	icmp_rx rx_i (
		.clk(clk),
		.reset(reset),
		.in_data(in_data),
		.in_valid(in_valid),
		.in_ready(in_ready),
		.in_last(in_last),
		.payload_q(payload_q.writer),
		.meta_q(meta_q.writer),
		.drop_count(drop_count)
	);

	// payload bytes of every message, good or not
	sync_fifo #(
		.T(icmp_byte_t),
		.DEPTH(PAYLOAD_DEPTH)
	) payload_fifo_i (
		.clk(clk),
		.reset(reset),
		.q(payload_q.storage)
	);

	sync_fifo #(
		.T(icmp_meta_t),
		.DEPTH(META_DEPTH)
	) meta_fifo_i (
		.clk(clk),
		.reset(reset),
		.q(meta_q.storage)
	);

	icmp_tx tx_i (
		.clk(clk),
		.reset(reset),
		.payload_q(payload_q.reader),
		.meta_q(meta_q.reader),
		.out_data(out_data),
		.out_valid(out_valid),
		.out_ready(out_ready),
		.out_last(out_last)
	);

endmodule

// File: test/clock_gen.sv
`timescale 1ns/1ns

module clock_gen #(
	parameter int PERIOD = 10,
	parameter int RESET_CYCLES = 4
) (
	output logic clk,
	output logic reset
);
	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = !clk;
	end

	initial begin
		reset = 1'b1;
		#(PERIOD * RESET_CYCLES); // released on a falling edge
		reset = 1'b0;
	end
endmodule

// File: test/icmp_echo_sva.sv
`timescale 1ns/1ns

module icmp_echo_sva (
	input logic clk,
	input logic reset,
	input logic [7:0] out_data,
	input logic out_valid,
	input logic out_ready,
	input logic out_last
);
	import icmp_pkg::*;

	logic [15:0] frame_pos; // bytes of the current reply already sent
	logic out_fire;

	assign out_fire = out_valid && out_ready;

	always_ff @(posedge clk or posedge reset) begin
		if (reset)
			frame_pos <= '0;
		else if (out_fire)
			frame_pos <= out_last ? 16'd0 : frame_pos + 16'd1;
	end

	hold_while_stalled: assert property (@(posedge clk) disable iff (reset)
		out_valid && !out_ready |=> out_valid && $stable(out_data) && $stable(out_last))
		else $error("output byte changed while out_ready was low");

	quiet_in_reset: assert property (@(posedge clk) reset |-> !out_valid)
		else $error("out_valid high during reset");

	// every reply opens with the reply type byte
	new_header_first: assert property (@(posedge clk) disable iff (reset)
		out_fire && frame_pos == 16'd0 |-> out_data == ICMP_ECHO_REPLY)
		else $error("output byte after out_last without a new header");

	no_early_last: assert property (@(posedge clk) disable iff (reset)
		out_fire && frame_pos < 16'(ICMP_HEADER_BYTES - 1) |-> !out_last)
		else $error("out_last inside the reply header");
endmodule

// File: test/icmp_echo_tb.sv
`timescale 1ns/1ns

module icmp_echo_tb;
	import icmp_pkg::*;

	localparam int PAYLOAD_DEPTH = 64;
	localparam int META_DEPTH = 4;

	typedef enum int {GOOD, BAD_SUM, OTHER_TYPE, BAD_CODE, RUNT} msg_kind_t;

	logic clk;
	logic reset;
	logic [7:0] in_data;
	logic in_valid;
	logic in_ready;
	logic in_last;
	logic [7:0] out_data;
	logic out_valid;
	logic out_ready;
	logic out_last;
	logic [15:0] drop_count;

	logic [31:0] lfsr = 32'h7795_c63c;
	logic [7:0] msg [0:127];
	int msg_len;
	logic [8:0] expected [$]; // {last, data}
	int errors = 0;
	int exp_drops = 0;
	int out_count = 0;
	int bytes_planned = 0;
	int cycle_count = 0;
	bit random_gaps = 1'b0;
	bit random_ready = 1'b0;

	clock_gen clock_gen_i (
		.clk(clk),
		.reset(reset)
	);

	icmp_echo #(
		.PAYLOAD_DEPTH(PAYLOAD_DEPTH),
		.META_DEPTH(META_DEPTH)
	) icmp_echo_i (
		.clk(clk),
		.reset(reset),
		.in_data(in_data),
		.in_valid(in_valid),
		.in_ready(in_ready),
		.in_last(in_last),
		.out_data(out_data),
		.out_valid(out_valid),
		.out_ready(out_ready),
		.out_last(out_last),
		.drop_count(drop_count)
	);

	bind icmp_echo icmp_echo_sva sva_i (
		.clk(clk),
		.reset(reset),
		.out_data(out_data),
		.out_valid(out_valid),
		.out_ready(out_ready),
		.out_last(out_last)
	);

	// 32 bit Galois LFSR, shifting right
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? (s >> 1) ^ 32'h8020_0003 : s >> 1;
	endfunction

	task automatic random_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_step(lfsr);
			v = {v[30:0], lfsr[0]};
		end
	endtask

	// folded sum of 16-bit words, odd tail padded with zero
	function automatic logic [15:0] ones_sum(input int len);
		int acc;
		acc = 0;
		for (int i = 0; i < len; i += 2)
			acc += {msg[i], (i + 1 < len) ? msg[i + 1] : 8'h00};
		while (acc > 65535)
			acc = (acc & 65535) + (acc >> 16);
		return acc[15:0];
	endfunction

	// reference model, queues the reply bytes or returns 0 for a drop
	function automatic int build_reply(input int len);
		logic [16:0] s;
		logic [15:0] csum;
		if (len < 8 || msg[0] != 8'd8 || msg[1] != 8'd0)
			return 0;
		if (ones_sum(len) != 16'hffff)
			return 0;
		s = {1'b0, msg[2], msg[3]} + 17'h0800;
		csum = s[15:0] + {15'd0, s[16]}; // end-around carry
		expected.push_back({1'b0, 8'h00});
		expected.push_back({1'b0, msg[1]});
		expected.push_back({1'b0, csum[15:8]});
		expected.push_back({1'b0, csum[7:0]});
		for (int i = 4; i < len; i++)
			expected.push_back({i == len - 1, msg[i]});
		return len;
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			errors++;
			$display("Error %s at %0t: got %0h, expected %0h", name, $time, got, exp);
		end
	endtask

	task automatic next_cycle();
		logic [31:0] r;
		@(negedge clk);
		r = 1;
		if (random_ready)
			random_bits(1, r);
		out_ready = r[0];
	endtask

	task automatic send_byte(input logic [7:0] d, input logic l);
		logic [31:0] r;
		logic done;
		r = 1;
		if (random_gaps)
			random_bits(2, r);
		while (r == 0) begin // idle gap
			in_valid = 1'b0;
			next_cycle();
			random_bits(2, r);
		end
		in_data = d;
		in_last = l;
		in_valid = 1'b1;
		done = 1'b0;
		while (!done) begin
			#1;
			done = in_ready; // settled until the next rising edge
			next_cycle();
		end
	endtask

	task automatic send_message(input msg_kind_t kind, input int n);
		logic [31:0] r;
		logic [15:0] c;
		msg_len = (kind == RUNT) ? n : ICMP_HEADER_BYTES + n;
		for (int i = 0; i < msg_len; i++) begin
			random_bits(8, r);
			msg[i] = r[7:0];
		end
		msg[0] = (kind == OTHER_TYPE) ? 8'd13 : 8'd8;
		msg[1] = (kind == BAD_CODE) ? (msg[1] | 8'h01) : 8'h00;
		if (msg_len >= 4) begin
			msg[2] = 8'h00;
			msg[3] = 8'h00;
			c = ~ones_sum(msg_len);
			msg[2] = c[15:8];
			msg[3] = (kind == BAD_SUM) ? c[7:0] ^ 8'h5a : c[7:0];
		end
		bytes_planned += msg_len;
		if (build_reply(msg_len) == 0)
			exp_drops++;
		for (int i = 0; i < msg_len; i++)
			send_byte(msg[i], i == msg_len - 1);
		in_valid = 1'b0;
		in_last = 1'b0;
	endtask

	task automatic wait_drained();
		int n;
		n = 0;
		while ((expected.size() != 0 || drop_count != exp_drops) && n < 4000) begin
			next_cycle();
			n++;
		end
		if (expected.size() != 0) begin
			errors++;
			$display("%0t: %0d expected reply bytes never came out", $time, expected.size());
		end
		check_value("drop_count", drop_count, exp_drops);
	endtask

	task automatic finish_run();
		$display("icmp_echo_tb: %0d errors, %0d reply bytes, %0d drops",
			errors, out_count, drop_count);
		if (errors == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	endtask

	// compare each accepted output byte
	always @(negedge clk) begin
		logic [8:0] e;
		#2;
		if (!reset && out_valid && out_ready) begin
			out_count++;
			if (expected.size() == 0) begin
				errors++;
				$display("%0t: output byte %0h with no reply pending", $time, out_data);
			end else begin
				e = expected.pop_front();
				check_value("out_data", out_data, e[7:0]);
				check_value("out_last", out_last, e[8]);
			end
		end
	end

	initial begin
		while (cycle_count <= 30 * bytes_planned + 1000) begin
			@(posedge clk);
			cycle_count++;
		end
		errors++;
		$display("timeout after %0d cycles, %0d reply bytes still expected",
			cycle_count, expected.size());
		finish_run();
	end

	initial begin
		logic [31:0] r;
		msg_kind_t kind;
		in_data = 8'h00;
		in_valid = 1'b0;
		in_last = 1'b0;
		out_ready = 1'b0;
		#15;
		check_value("in_ready", in_ready, 0);
		check_value("out_valid", out_valid, 0);
		check_value("drop_count", drop_count, 0);
		wait (!reset);
		next_cycle();

		send_message(GOOD, 1);
		send_message(GOOD, 40);
		repeat (8) begin
			random_bits(6, r);
			send_message(GOOD, 1 + r % 40);
		end
		wait_drained();

		// one drop at a time
		repeat (2) begin
			send_message(BAD_SUM, 12);
			wait_drained();
			send_message(OTHER_TYPE, 5);
			wait_drained();
			send_message(BAD_CODE, 7);
			wait_drained();
		end
		for (int n = 1; n < ICMP_HEADER_BYTES; n++) begin
			send_message(RUNT, n);
			wait_drained();
		end
		send_message(GOOD, 0); // header only
		wait_drained();

		random_gaps = 1'b1;
		random_ready = 1'b1;
		repeat (40) begin
			random_bits(4, r);
			kind = (r < 10) ? GOOD : msg_kind_t'(1 + (r - 10) % 4);
			random_bits(6, r);
			send_message(kind, (kind == RUNT) ? 1 + r % 7 : r % 46);
		end
		send_message(GOOD, PAYLOAD_DEPTH);
		wait_drained();

		random_ready = 1'b0;
		repeat (40) next_cycle(); // any stray byte is flagged here
		check_value("drop_count", drop_count, exp_drops);
		finish_run();
	end
endmodule

// File: icmp_echo.f
rtl/icmp_pkg.sv
rtl/fifo_if.sv
rtl/sync_fifo.sv
rtl/icmp_rx.sv
rtl/icmp_tx.sv
rtl/icmp_echo.sv
test/clock_gen.sv
test/icmp_echo_sva.sv
test/icmp_echo_tb.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module icmp_echo_tb \
	-f icmp_echo.f -o icmp_echo_sim &&
./obj_dir/icmp_echo_sim | tee /dev/stderr | grep -qx "All checks passed" &&
echo "PASS" ||
{ echo "FAIL"; exit 1; }
